/* logic/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Byte address width of the fetch path
`define FETCH_ADDR_W 32

// Cache line geometry
`define FETCH_LINE_BYTES 16
`define FETCH_INDEX_W 6

// Address bits above index and line offset
`define FETCH_TAG_W 22

// 64-bit AXI beats per line refill
`define FETCH_BEATS 2

`endif

/* logic/fetch_pkg.sv */
`include "fetch_config.svh"

package fetch_pkg;

    // One full cache line, beat 0 in the low half
    typedef logic [`FETCH_LINE_BYTES*8-1:0] line_t;

    // Core side fetch request
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] pc;
    } fetch_req_t;

    // Instruction handed to decode
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [31:0]              inst;
    } fetch_rsp_t;

    // AXI read address channel, id and burst tied off outside
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] addr;
        logic [7:0]               len;
        logic [2:0]               size;
    } axi_ar_t;

    // AXI read data channel
    typedef struct packed {
        logic [63:0] data;
        logic        last;
    } axi_r_t;

    // SRAM macro pins, cen and wen active low
    typedef struct packed {
        logic [`FETCH_INDEX_W-1:0]      addr;
        logic                           cen;
        logic                           wen;
        logic [`FETCH_LINE_BYTES*8-1:0] wmask;
        logic [`FETCH_LINE_BYTES*8-1:0] wdata;
    } sram_req_t;

endpackage

/* logic/pc_gen.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module pc_gen (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     redirect,
    input  logic [`FETCH_ADDR_W-1:0] redirect_pc,
    output fetch_pkg::fetch_req_t    req,
    output logic                     req_valid,
    input  logic                     req_ready
);

    localparam logic [`FETCH_ADDR_W-1:0] RESET_PC = 32'h8000_0000;
    localparam logic [`FETCH_ADDR_W-1:0] INST_BYTES = 4;

    logic [`FETCH_ADDR_W-1:0] pc_q;
    logic                     run_q;
    logic                     req_fire;

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////

    assign req_fire = req_valid && req_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc_q  <= RESET_PC;
            run_q <= 1'b0;
        end else begin
            // Fetch starts the cycle after reset and never stops
            run_q <= 1'b1;
            if (redirect) begin
                pc_q <= redirect_pc;
            end else if (req_fire) begin
                pc_q <= pc_q + INST_BYTES;
            end
        end
    end

    //////////////////////////////////////////////////
    // Request port
    //////////////////////////////////////////////////

    // No request while the target is being loaded
    assign req_valid = run_q && !redirect;

    assign req = '{pc: pc_q};

endmodule

/* logic/refill_buffer.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module refill_buffer (
    input  logic              clock,
    input  logic              rst_n,
    input  fetch_pkg::axi_r_t r,
    input  logic              r_valid,
    output logic              r_ready,
    output fetch_pkg::line_t  fill_line,
    output logic              fill_valid
);

    localparam int BEAT_BITS = (`FETCH_LINE_BYTES * 8) / `FETCH_BEATS;
    localparam int BEAT_W    = $clog2(`FETCH_BEATS);

    logic [BEAT_W-1:0] beat_q;
    fetch_pkg::line_t  line_q;
    logic              fill_q;
    logic              beat_fire;

    // Refill always has room, one line in flight at a time
    assign r_ready   = 1'b1;
    assign beat_fire = r_valid && r_ready;

    //////////////////////////////////////////////////
    // Beat counter and fill strobe
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            beat_q <= '0;
            fill_q <= 1'b0;
        end else begin
            fill_q <= 1'b0;
            if (beat_fire) begin
                if (r.last) begin
                    beat_q <= '0;
                    fill_q <= 1'b1;
                end else begin
                    beat_q <= beat_q + 1'b1;
                end
            end
        end
    end

    // Line assembly, first beat lands in the low half
    always_ff @(posedge clock) begin
        if (beat_fire) begin
            line_q[beat_q*BEAT_BITS +: BEAT_BITS] <= r.data;
        end
    end

    assign fill_line  = line_q;
    assign fill_valid = fill_q;

endmodule

/* logic/icache.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module icache (
    input  logic                           clock,
    input  logic                           rst_n,
    input  fetch_pkg::fetch_req_t          req,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic                           flush,
    output fetch_pkg::axi_ar_t             ar,
    output logic                           ar_valid,
    input  logic                           ar_ready,
    input  fetch_pkg::line_t               fill_line,
    input  logic                           fill_valid,
    output fetch_pkg::sram_req_t           sram,
    input  logic [`FETCH_LINE_BYTES*8-1:0] sram_rdata,
    output fetch_pkg::fetch_rsp_t          rsp,
    output logic                           rsp_valid
);

    localparam int OFFSET_W   = $clog2(`FETCH_LINE_BYTES);
    localparam int LINES      = 1 << `FETCH_INDEX_W;
    localparam int WORD_SEL_W = OFFSET_W - 2;

    // Miss handling states
    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_WAIT
    } state_t;

    state_t                    state_q;
    logic [`FETCH_TAG_W-1:0]   tag_mem [LINES];
    logic [LINES-1:0]          line_valid_q;
    logic [`FETCH_ADDR_W-1:0]  pc_q;
    logic                      hit_q;

    logic [`FETCH_INDEX_W-1:0] req_index;
    logic [`FETCH_TAG_W-1:0]   req_tag;
    logic [`FETCH_INDEX_W-1:0] miss_index;
    logic [WORD_SEL_W-1:0]     word_sel;
    logic                      req_fire;
    logic                      fill_fire;
    logic                      lookup_hit;
    fetch_pkg::line_t          rsp_line;

    //////////////////////////////////////////////////
    // Address split and lookup
    //////////////////////////////////////////////////

    assign req_index  = req.pc[OFFSET_W +: `FETCH_INDEX_W];
    assign req_tag    = req.pc[`FETCH_ADDR_W-1 -: `FETCH_TAG_W];
    assign miss_index = pc_q[OFFSET_W +: `FETCH_INDEX_W];
    assign word_sel   = pc_q[OFFSET_W-1:2];

    // Core may only hand over a PC while no miss is open
    assign req_ready = (state_q == S_IDLE);
    assign req_fire  = req_valid && req_ready;
    assign fill_fire = (state_q == S_WAIT) && fill_valid;

    assign lookup_hit = line_valid_q[req_index] && (tag_mem[req_index] == req_tag);

    // PC of the request in flight
    always_ff @(posedge clock) begin
        if (req_fire) begin
            pc_q <= req.pc;
        end
    end

    //////////////////////////////////////////////////
    // Miss FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            hit_q   <= 1'b0;
        end else begin
            // Hit data comes back from the SRAM next cycle
            hit_q <= req_fire && lookup_hit;
            case (state_q)
                S_IDLE: begin
                    if (req_fire && !lookup_hit) begin
                        state_q <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (ar_ready) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (fill_valid) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // Line request, aligned down to the line
    assign ar_valid = (state_q == S_ADDR);
    assign ar = '{
        addr: {pc_q[`FETCH_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}},
        len:  8'(`FETCH_BEATS - 1),
        size: 3'd3
    };

    //////////////////////////////////////////////////
    // Tag and valid arrays
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            line_valid_q <= '0;
        end else begin
            if (flush) begin
                line_valid_q <= '0;
            end
            // A fill landing with a flush still counts
            if (fill_fire) begin
                line_valid_q[miss_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill_fire) begin
            tag_mem[miss_index] <= pc_q[`FETCH_ADDR_W-1 -: `FETCH_TAG_W];
        end
    end

    //////////////////////////////////////////////////
    // SRAM port
    //////////////////////////////////////////////////

    // wmask is a per-bit write enable, high means write
    always_comb begin
        sram.addr  = req_index;
        sram.cen   = 1'b1;
        sram.wen   = 1'b1;
        sram.wmask = '0;
        sram.wdata = fill_line;
        if (fill_fire) begin
            sram.addr  = miss_index;
            sram.cen   = 1'b0;
            sram.wen   = 1'b0;
            sram.wmask = '1;
        end else if (req_fire) begin
            sram.cen = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Instruction delivery
    //////////////////////////////////////////////////

    // On a fill the word bypasses the SRAM
    assign rsp_line  = fill_fire ? fill_line : sram_rdata;
    assign rsp_valid = hit_q || fill_fire;
    assign rsp = '{
        pc:   pc_q,
        inst: rsp_line[word_sel*32 +: 32]
    };

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_top (
    input  logic                           clock,
    input  logic                           rst_n,

    // Redirect and flush from the back end
    input  logic                           redirect,
    input  logic [`FETCH_ADDR_W-1:0]       redirect_pc,
    input  logic                           flush,

    // Instruction out to decode
    output fetch_pkg::fetch_rsp_t          rsp,
    output logic                           rsp_valid,

    // AXI master, read address
    output fetch_pkg::axi_ar_t             ar,
    output logic                           ar_valid,
    input  logic                           ar_ready,

    // AXI master, read data
    input  fetch_pkg::axi_r_t              r,
    input  logic                           r_valid,
    output logic                           r_ready,

    // Cache data SRAM macro
    output fetch_pkg::sram_req_t           sram,
    input  logic [`FETCH_LINE_BYTES*8-1:0] sram_rdata
);

    fetch_pkg::fetch_req_t req;
    logic                  req_valid;
    logic                  req_ready;
    fetch_pkg::line_t      fill_line;
    logic                  fill_valid;

    //////////////////////////////////////////////////
    // Fetch pipeline
    //////////////////////////////////////////////////

    pc_gen pc_gen_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready)
    );

    icache icache_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .flush      (flush),
        .ar         (ar),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .fill_line  (fill_line),
        .fill_valid (fill_valid),
        .sram       (sram),
        .sram_rdata (sram_rdata),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid)
    );

    // R channel into line assembly
    refill_buffer refill_buffer_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .r          (r),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .fill_line  (fill_line),
        .fill_valid (fill_valid)
    );

endmodule

/* dv/mem_models.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module axi_mem_model (
    input  logic               clock,
    input  logic               rst_n,
    input  fetch_pkg::axi_ar_t ar,
    input  logic               ar_valid,
    output logic               ar_ready,
    output fetch_pkg::axi_r_t  r,
    output logic               r_valid,
    input  logic               r_ready
);

    logic                     busy;
    logic [`FETCH_ADDR_W-1:0] beat_addr;
    int unsigned              beats_left;
    int unsigned              wait_cnt;

    // Word at byte address a reads back as a XOR 5A5A_0000
    function automatic logic [31:0] mem_word(input logic [`FETCH_ADDR_W-1:0] addr);
        return addr ^ 32'h5A5A_0000;
    endfunction

    initial begin
        ar_ready   = 1'b0;
        r_valid    = 1'b0;
        r          = '0;
        busy       = 1'b0;
        beat_addr  = '0;
        beats_left = 0;
        wait_cnt   = 2;
    end

    //////////////////////////////////////////////////
    // Address accept and burst return
    //////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!rst_n) begin
            ar_ready = 1'b0;
            r_valid  = 1'b0;
            r        = '0;
            busy     = 1'b0;
            wait_cnt = 2;
        end else begin
            ar_ready = 1'b0;
            // Beat driven last cycle was taken at the rising edge
            if (r_valid && r_ready) begin
                r_valid    = 1'b0;
                beat_addr  = beat_addr + 8;
                beats_left = beats_left - 1;
                if (beats_left == 0) begin
                    busy     = 1'b0;
                    wait_cnt = $urandom % 4;
                end
            end
            if (busy) begin
                // Random bubbles between beats
                if (($urandom % 4) != 0) begin
                    r_valid = 1'b1;
                    r.data  = {mem_word(beat_addr + 4), mem_word(beat_addr)};
                    r.last  = (beats_left == 1);
                end
            end else if (ar_valid) begin
                if (wait_cnt == 0) begin
                    ar_ready   = 1'b1;
                    busy       = 1'b1;
                    beat_addr  = ar.addr;
                    beats_left = ar.len + 1;
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
    end

endmodule

module sram_model (
    input  logic                           clock,
    input  fetch_pkg::sram_req_t           sram,
    output logic [`FETCH_LINE_BYTES*8-1:0] rdata
);

    localparam int LINES = 1 << `FETCH_INDEX_W;

    logic [`FETCH_LINE_BYTES*8-1:0] mem [LINES];
    logic [`FETCH_LINE_BYTES*8-1:0] rd_q;

    // Power-up contents differ per entry so a stale read shows up
    initial begin
        for (int i = 0; i < LINES; i++) begin
            mem[i] = {4{32'hBAD0_0000 | 32'(i)}};
        end
        rd_q  = '0;
        rdata = '0;
    end

    always @(posedge clock) begin
        if (!sram.cen) begin
            if (!sram.wen) begin
                mem[sram.addr] <= (mem[sram.addr] & ~sram.wmask) | (sram.wdata & sram.wmask);
            end else begin
                rd_q <= mem[sram.addr];
            end
        end
    end

    // Read data shows up on the pins half a cycle later
    always @(negedge clock) begin
        rdata <= rd_q;
    end

endmodule

/* dv/fetch_tb.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_tb;

    localparam logic [31:0] RESET_PC  = 32'h8000_0000;
    localparam logic [31:0] DATA_MASK = 32'h5A5A_0000;

    logic                           clock;
    logic                           rst_n;
    logic                           redirect;
    logic [`FETCH_ADDR_W-1:0]       redirect_pc;
    logic                           flush;
    fetch_pkg::fetch_rsp_t          rsp;
    logic                           rsp_valid;
    fetch_pkg::axi_ar_t             ar;
    logic                           ar_valid;
    logic                           ar_ready;
    fetch_pkg::axi_r_t              r;
    logic                           r_valid;
    logic                           r_ready;
    fetch_pkg::sram_req_t           sram;
    logic [`FETCH_LINE_BYTES*8-1:0] sram_rdata;

    // Reference state updated on rising edges
    logic        rst_n_q = 1'b1;
    logic [31:0] exp_pc;
    logic        redir_pending;
    logic        redir_stale;
    logic [31:0] redir_target;
    logic        ar_open;
    logic [31:0] ar_line;
    logic        ar_wait_q;
    logic [63:0] ref_valid;
    logic [21:0] ref_tag [64];
    int unsigned rsp_count;
    logic        rsp_cached;
    logic        ar_cached;

    always #4 clock = ~clock;

    fetch_top fetch_top_inst (.*);
    axi_mem_model axi_mem_model_inst (.*);
    sram_model sram_model_inst (.clock(clock), .sram(sram), .rdata(sram_rdata));

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    //////////////////////////////////////////////////
    // Reference model of a 64-line direct-mapped cache
    //////////////////////////////////////////////////

    assign rsp_cached = ref_valid[rsp.pc[9:4]] && (ref_tag[rsp.pc[9:4]] == rsp.pc[31:10]);
    assign ar_cached  = ref_valid[ar.addr[9:4]] && (ref_tag[ar.addr[9:4]] == ar.addr[31:10]);

    always @(posedge clock) begin
        rst_n_q <= rst_n;
        if (!rst_n) begin
            exp_pc        <= RESET_PC;
            redir_pending <= 1'b0;
            redir_stale   <= 1'b0;
            redir_target  <= '0;
            ar_open       <= 1'b0;
            ar_line       <= '0;
            ar_wait_q     <= 1'b0;
            ref_valid     <= '0;
            rsp_count     <= 0;
        end else begin
            ar_wait_q <= ar_valid && !ar_ready;
            if (flush) begin
                ref_valid <= '0;
            end
            if (ar_valid && ar_ready) begin
                ar_open <= 1'b1;
                ar_line <= ar.addr;
            end
            if (rsp_valid) begin
                rsp_count <= rsp_count + 1;
                if (redir_pending && rsp.pc == redir_target) begin
                    redir_pending <= 1'b0;
                    redir_stale   <= 1'b0;
                    exp_pc        <= redir_target + 32'd4;
                end else begin
                    // One response from before the redirect may still arrive
                    redir_stale <= redir_pending;
                    exp_pc      <= exp_pc + 32'd4;
                end
                // Refill response installs its line
                if (ar_open) begin
                    ar_open                <= 1'b0;
                    ref_valid[rsp.pc[9:4]] <= 1'b1;
                    ref_tag[rsp.pc[9:4]]   <= rsp.pc[31:10];
                end
            end
            if (redirect) begin
                redir_pending <= 1'b1;
                redir_stale   <= 1'b0;
                redir_target  <= redirect_pc;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_reset_state: assert property (@(posedge clock)
        !rst_n_q |-> (!rsp_valid && !ar_valid && sram.cen && sram.wen))
        else abort_run($sformatf(
            "mismatch at %0t: rsp_valid/ar_valid/sram.cen/sram.wen expected 0011 actual %b%b%b%b",
            $time, $sampled(rsp_valid), $sampled(ar_valid), $sampled(sram.cen),
            $sampled(sram.wen)));

    a_r_ready: assert property (@(posedge clock) r_ready)
        else abort_run($sformatf("mismatch at %0t: r_ready expected 1 actual %b", $time,
            $sampled(r_ready)));

    a_inst_data: assert property (@(posedge clock) disable iff (!rst_n)
        rsp_valid |-> (rsp.inst == (rsp.pc ^ DATA_MASK)))
        else abort_run($sformatf("mismatch at %0t: rsp.inst expected %h actual %h", $time,
            $sampled(rsp.pc) ^ DATA_MASK, $sampled(rsp.inst)));

    a_pc_order: assert property (@(posedge clock) disable iff (!rst_n)
        rsp_valid |-> ((rsp.pc == exp_pc && !(redir_pending && redir_stale))
            || (redir_pending && rsp.pc == redir_target)))
        else abort_run($sformatf("mismatch at %0t: rsp.pc expected %h actual %h", $time,
            $sampled(redir_pending) ? $sampled(redir_target) : $sampled(exp_pc),
            $sampled(rsp.pc)));

    a_ar_format: assert property (@(posedge clock) disable iff (!rst_n)
        (ar_valid && ar_ready) |-> ({ar.len, ar.size, ar.addr[3:0]} == {8'd1, 3'd3, 4'h0}))
        else abort_run($sformatf(
            "mismatch at %0t: ar.len/size/addr[3:0] expected 1/3/0 actual %0d/%0d/%h",
            $time, $sampled(ar.len), $sampled(ar.size), $sampled(ar.addr[3:0])));

    a_ar_needed: assert property (@(posedge clock) disable iff (!rst_n)
        (ar_valid && ar_ready) |-> (!ar_cached && !ar_open))
        else abort_run($sformatf("AR at %0t for line %h that is cached or during a refill",
            $time, $sampled(ar.addr)));

    a_ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
        ar_wait_q |-> ar_valid)
        else abort_run($sformatf("ar_valid dropped at %0t before ar_ready", $time));

    a_hit_miss: assert property (@(posedge clock) disable iff (!rst_n)
        rsp_valid |-> (ar_open != rsp_cached))
        else abort_run($sformatf("response at %0t for pc %h: line cached %0d, AR issued %0d",
            $time, $sampled(rsp.pc), $sampled(rsp_cached), $sampled(ar_open)));

    a_fill_line: assert property (@(posedge clock) disable iff (!rst_n)
        (rsp_valid && ar_open) |-> ({rsp.pc[31:4], 4'h0} == ar_line))
        else abort_run($sformatf("mismatch at %0t: ar.addr expected %h actual %h", $time,
            {$sampled(rsp.pc[31:4]), 4'h0}, $sampled(ar_line)));

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic redirect_to(input logic [31:0] target, input logic with_flush);
        redirect    = 1'b1;
        redirect_pc = target;
        flush       = with_flush;
        @(negedge clock);
        redirect = 1'b0;
        flush    = 1'b0;
    endtask

    task automatic wait_responses(input int unsigned n);
        int unsigned start;
        int unsigned cycles;
        start  = rsp_count;
        cycles = 0;
        while ((rsp_count - start) < n && cycles < 40 * n + 50) begin
            @(negedge clock);
            cycles++;
        end
        if ((rsp_count - start) < n) begin
            abort_run($sformatf("timeout: %0d of %0d responses after %0d cycles",
                rsp_count - start, n, cycles));
        end
    endtask

    initial begin
        logic [31:0] target;
        clock       = 1'b0;
        rst_n       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        flush       = 1'b0;
        void'($urandom(27645));
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        // Straight run from the reset vector over six lines
        wait_responses(24);
        // Back to the start where every line hits
        redirect_to(RESET_PC, 1'b0);
        wait_responses(12);
        // Same index one KB up evicts the old lines so they miss again
        redirect_to(RESET_PC + 32'h400, 1'b0);
        wait_responses(8);
        redirect_to(RESET_PC, 1'b0);
        wait_responses(8);
        // Flush along with a jump into lines that were cached
        redirect_to(RESET_PC + 32'h8, 1'b1);
        wait_responses(8);

        // Random jumps over two KB with an occasional flush
        repeat (12) begin
            target = RESET_PC + (($urandom % 512) << 2);
            redirect_to(target, ($urandom % 4) == 0);
            wait_responses(6 + $urandom % 8);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+logic
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/refill_buffer.sv
logic/icache.sv
logic/fetch_top.sv
dv/mem_models.sv
dv/fetch_tb.sv
